//--- sim.f
+incdir+rtl
rtl/commit_pkg.sv
rtl/exception_check.sv
rtl/stage_reg.sv
rtl/data_commit.sv
rtl/commit_stage.sv
verif/tb_dmem.sv
verif/tb_commit_stage.sv

//--- run.sh
#!/bin/sh
# build and run the commit stage testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_commit_stage \
    -f sim.f -o vsim_commit \
    && ./obj_dir/vsim_commit | tee /dev/stderr | grep -qx "Result: PASSED" \
    && exit 0 || exit 1

//--- verif/tb_commit_stage.sv
`timescale 1ns/1ns
`default_nettype none

`include "commit_params.svh"

module tb_commit_stage;
    import commit_pkg::*;

    localparam int NUM_BUNDLES = 300;
    localparam int CYCLE_LIMIT = NUM_BUNDLES * 10;

    typedef struct packed {
        writeback_t [`COMMIT_SLOTS-1:0] wb;
        redirect_t                      redirect;
        exception_t                     exc;
    } expect_t;

    typedef struct packed {
        word_t     addr;
        mem_size_e size;
        word_t     data;
    } store_t;

    logic                           clk;
    logic                           reset;
    exec_bundle_t                   in;
    logic                           in_valid;
    logic                           irq;
    logic                           finish;
    logic                           dmem_req;
    logic                           dmem_wt;
    mem_size_e                      dmem_size;
    word_t                          dmem_addr;
    word_t                          dmem_wd;
    logic                           dmem_addr_ok;
    logic                           dmem_data_ok;
    word_t                          dmem_rd;
    writeback_t [`COMMIT_SLOTS-1:0] wb;
    redirect_t                      redirect;
    exception_t                     exception;
    logic                           store_valid;
    word_t                          store_addr;
    mem_size_e                      store_size;
    word_t                          store_data;
    int                             store_count;

    logic [31:0] rng;
    int          errors;
    int          checks;
    int          cycles;
    int          accepted;
    expect_t     held;
    logic        held_busy;
    store_t      exp_stores[$];
    store_t      obs_stores[$];

    commit_stage u_dut (
        .clk, .reset, .in, .in_valid, .irq, .finish,
        .dmem_req, .dmem_wt, .dmem_size, .dmem_addr, .dmem_wd,
        .dmem_addr_ok, .dmem_data_ok, .dmem_rd,
        .wb, .redirect, .exception
    );

    tb_dmem #(.SEED(32'h745b3481)) u_mem (
        .clk, .reset, .dmem_req, .dmem_wt, .dmem_size, .dmem_addr, .dmem_wd,
        .dmem_addr_ok, .dmem_data_ok, .dmem_rd,
        .store_valid, .store_addr, .store_size, .store_data, .store_count
    );

    initial
        clk = 1'b0;
    always #5 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic word_t memory_word(input word_t a);
        return {a[31:2], 2'b00} ^ 32'h5A5A5A5A;
    endfunction

    function automatic word_t aligned_load(input word_t a, input mem_size_e sz, input logic sx);
        word_t      w;
        logic [7:0] b;
        logic [15:0] h;
        w = memory_word(a);
        b = w[8*a[1:0] +: 8];
        h = a[1] ? w[31:16] : w[15:0];
        if (sz == SIZE_BYTE)
            return {{24{sx & b[7]}}, b};
        if (sz == SIZE_HALF)
            return {{16{sx & h[15]}}, h};
        return w;
    endfunction

    function automatic exc_code_e slot_cause(input exec_data_t s);
        logic bad;
        bad = (s.size == SIZE_HALF && s.result[0]) || (s.size == SIZE_WORD && s.result[1:0] != 0);
        if (!s.valid)
            return EXC_NONE;
        if (s.overflow)
            return EXC_OV;
        if (s.kind == OP_SYSCALL)
            return EXC_SYS;
        if (s.kind == OP_BREAK)
            return EXC_BP;
        if (bad && s.kind == OP_LOAD)
            return EXC_ADEL;
        if (bad && s.kind == OP_STORE)
            return EXC_ADES;
        return EXC_NONE;
    endfunction

    function automatic exc_code_e first_cause(input exec_bundle_t b, input logic irq_in);
        return (irq_in && b[0].valid) ? EXC_INT : slot_cause(b[0]);
    endfunction

    function automatic expect_t expected_outputs(input exec_bundle_t b, input logic irq_in);
        expect_t   e;
        exc_code_e c0;
        exc_code_e c1;
        logic      killed;
        logic      writes;
        e = '0;
        c0 = first_cause(b, irq_in);
        c1 = (c0 == EXC_NONE) ? slot_cause(b[1]) : EXC_NONE;
        if (c0 != EXC_NONE)
        begin
            e.exc.valid = 1'b1;
            e.exc.code = c0;
            e.exc.epc = b[0].pc;
            if (c0 == EXC_ADEL || c0 == EXC_ADES)
                e.exc.bad_addr = b[0].result;
        end
        else if (c1 != EXC_NONE)
        begin
            e.exc.valid = 1'b1;
            e.exc.code = c1;
            e.exc.epc = b[1].pc;
            e.exc.slot = 1'b1;
        end
        for (int i = 0; i < `COMMIT_SLOTS; i++)
        begin
            killed = e.exc.valid && (i == 1 || !e.exc.slot);
            writes = b[i].kind == OP_LOAD
                  || ((b[i].kind == OP_ALU || b[i].kind == OP_BRANCH) && b[i].dest != 0);
            if (b[i].valid && !killed && writes)
            begin
                e.wb[i].valid = 1'b1;
                e.wb[i].dest = b[i].dest;
                if (b[i].kind == OP_LOAD)
                    e.wb[i].value = aligned_load(b[i].result, b[i].size, b[i].sign_ext);
                else
                    e.wb[i].value = b[i].result;
            end
        end
        if (e.exc.valid)
        begin
            e.redirect.valid = 1'b1;
            e.redirect.pc = `COMMIT_EXC_VECTOR;
            e.redirect.from_exception = 1'b1;
        end
        else
        begin
            for (int i = `COMMIT_SLOTS - 1; i >= 0; i--)
            begin
                if (b[i].valid && b[i].kind == OP_BRANCH && b[i].branch_taken)
                begin
                    e.redirect.valid = 1'b1;
                    e.redirect.pc = b[i].branch_target;
                end
            end
        end
        return e;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        errors = errors + 1;
        $display("[FAIL] %s expected %h got %h at cycle %0d", name, exp, got, cycles);
    endtask

    task automatic build_slot(input logic first, output exec_data_t s);
        logic [31:0] r;
        int          sel;
        rng = xorshift(rng);
        r = rng;
        s = '0;
        s.valid = r[3:0] != 0;
        sel = int'(r[7:4]);
        if (sel < 5 || (!first && sel < 9))
            s.kind = OP_ALU;
        else if (first && sel < 8)
            s.kind = OP_LOAD;
        else if (first && sel < 10)
            s.kind = OP_STORE;
        else if (sel < 12)
            s.kind = OP_BRANCH;
        else if (sel == 12)
            s.kind = OP_SYSCALL;
        else if (sel == 13)
            s.kind = OP_BREAK;
        else
            s.kind = OP_NONE;
        s.size = (r[9:8] == 2'd3) ? SIZE_WORD : mem_size_e'(r[9:8]);
        s.sign_ext = r[10];
        s.overflow = r[15:11] == 0;
        s.dest = r[20:16];
        s.branch_taken = r[21];
        rng = xorshift(rng);
        s.pc = {rng[31:2], 2'b00};
        rng = xorshift(rng);
        s.result = rng;
        // mostly aligned; the rest raise address errors.
        if (r[24:22] != 0 && s.size == SIZE_HALF)
            s.result[0] = 1'b0;
        if (r[24:22] != 0 && s.size == SIZE_WORD)
            s.result[1:0] = 2'b00;
        rng = xorshift(rng);
        s.store_data = rng;
        s.branch_target = {rng[15:2], rng[31:16], 2'b00};
    endtask

    // a raised request must carry the slot 0 memory op of the offered bundle.
    task automatic check_request();
        logic want;
        logic is_store;
        want = in_valid && in[0].valid && first_cause(in, irq) == EXC_NONE
            && (in[0].kind == OP_LOAD || in[0].kind == OP_STORE);
        is_store = in[0].kind == OP_STORE;
        if (!want)
        begin
            errors = errors + 1;
            $display("memory request raised with no memory op to issue at cycle %0d", cycles);
        end
        else
        begin
            if (dmem_addr !== in[0].result)
                report_mismatch("dmem_addr", dmem_addr, in[0].result);
            if (dmem_size !== in[0].size)
                report_mismatch("dmem_size", 32'(dmem_size), 32'(in[0].size));
            if (dmem_wt !== is_store)
                report_mismatch("dmem_wt", 32'(dmem_wt), 32'(is_store));
        end
    endtask

    task automatic compare_outputs(input expect_t e);
        checks = checks + 1;
        for (int i = 0; i < `COMMIT_SLOTS; i++)
        begin
            if (wb[i].valid !== e.wb[i].valid)
                report_mismatch($sformatf("wb[%0d].valid", i), 32'(wb[i].valid),
                                32'(e.wb[i].valid));
            if (e.wb[i].valid && wb[i].dest !== e.wb[i].dest)
                report_mismatch($sformatf("wb[%0d].dest", i), 32'(wb[i].dest),
                                32'(e.wb[i].dest));
            if (e.wb[i].valid && wb[i].value !== e.wb[i].value)
                report_mismatch($sformatf("wb[%0d].value", i), wb[i].value, e.wb[i].value);
        end
        if (redirect.valid !== e.redirect.valid)
            report_mismatch("redirect.valid", 32'(redirect.valid), 32'(e.redirect.valid));
        if (e.redirect.valid && redirect.pc !== e.redirect.pc)
            report_mismatch("redirect.pc", redirect.pc, e.redirect.pc);
        if (e.redirect.valid && redirect.from_exception !== e.redirect.from_exception)
            report_mismatch("redirect.from_exception", 32'(redirect.from_exception),
                            32'(e.redirect.from_exception));
        if (exception.valid !== e.exc.valid)
            report_mismatch("exception.valid", 32'(exception.valid), 32'(e.exc.valid));
        if (e.exc.valid && exception.code !== e.exc.code)
            report_mismatch("exception.code", 32'(exception.code), 32'(e.exc.code));
        if (e.exc.valid && exception.epc !== e.exc.epc)
            report_mismatch("exception.epc", exception.epc, e.exc.epc);
        if (e.exc.valid && exception.bad_addr !== e.exc.bad_addr)
            report_mismatch("exception.bad_addr", exception.bad_addr, e.exc.bad_addr);
        if (e.exc.valid && exception.slot !== e.exc.slot)
            report_mismatch("exception.slot", 32'(exception.slot), 32'(e.exc.slot));
    endtask

    ////////////////////////////////////////
    // reference model, sampled mid-cycle.
    ////////////////////////////////////////

    always @(negedge clk)
    begin
        store_t st;
        store_t ob;
        if (!reset)
        begin
            if (store_valid)
                obs_stores.push_back(store_t'{store_addr, store_size, store_data});
            if (dmem_req)
                check_request();
            if (finish)
            begin
                compare_outputs(held);
                if (in_valid)
                begin
                    accepted = accepted + 1;
                    if (in[0].valid && in[0].kind == OP_STORE
                        && first_cause(in, irq) == EXC_NONE)
                    begin
                        st.addr = in[0].result;
                        st.size = in[0].size;
                        st.data = (in[0].size == SIZE_BYTE) ? {4{in[0].store_data[7:0]}}
                                : (in[0].size == SIZE_HALF) ? {2{in[0].store_data[15:0]}}
                                : in[0].store_data;
                        exp_stores.push_back(st);
                    end
                end
                // the bundle behind a committed exception is flushed.
                if (held.exc.valid || !in_valid)
                begin
                    held = '0;
                    held_busy = 1'b0;
                end
                else
                begin
                    held = expected_outputs(in, irq);
                    held_busy = 1'b1;
                end
            end
            else
                compare_outputs('0);
            while (exp_stores.size() > 0 && obs_stores.size() > 0)
            begin
                st = exp_stores.pop_front();
                ob = obs_stores.pop_front();
                if (ob.addr !== st.addr)
                    report_mismatch("store addr", ob.addr, st.addr);
                if (ob.size !== st.size)
                    report_mismatch("store size", 32'(ob.size), 32'(st.size));
                if (ob.data !== st.data)
                    report_mismatch("store data", ob.data, st.data);
            end
        end
    end

    always @(posedge clk)
    begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT)
        begin
            $display("timeout: run did not complete within %0d cycles", CYCLE_LIMIT);
            $display("Result: FAILED");
            $finish;
        end
    end

    initial
    begin
        exec_data_t s0;
        exec_data_t s1;
        rng = 32'h745b3481;
        errors = 0;
        checks = 0;
        cycles = 0;
        accepted = 0;
        held = '0;
        held_busy = 1'b0;
        reset = 1'b1;
        in = '0;
        in_valid = 1'b0;
        irq = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;
        for (int n = 0; n < NUM_BUNDLES; n++)
        begin
            rng = xorshift(rng);
            if (rng[2:0] == 0)
            begin
                in_valid = 1'b0;
                irq = 1'b0;
                @(posedge clk);
                #1;
            end
            irq = rng[7:4] == 0;
            build_slot(1'b1, s0);
            build_slot(1'b0, s1);
            in[0] = s0;
            in[1] = s1;
            in_valid = 1'b1;
            // held until the stage takes it.
            do
                @(negedge clk);
            while (!finish);
            @(posedge clk);
            #1;
        end
        in_valid = 1'b0;
        irq = 1'b0;
        while (held_busy || exp_stores.size() != 0 || obs_stores.size() != 0)
            @(posedge clk);
        $display("bundles %0d  checks %0d  stores %0d  errors %0d",
                 accepted, checks, store_count, errors);
        if (errors == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- verif/tb_dmem.sv
`timescale 1ns/1ns
`default_nettype none

module tb_dmem #(
    parameter logic [31:0] SEED = 32'h745b3481
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  dmem_req,
    input  logic                  dmem_wt,
    input  commit_pkg::mem_size_e dmem_size,
    input  commit_pkg::word_t     dmem_addr,
    input  commit_pkg::word_t     dmem_wd,
    output logic                  dmem_addr_ok,
    output logic                  dmem_data_ok,
    output commit_pkg::word_t     dmem_rd,
    output logic                  store_valid,
    output commit_pkg::word_t     store_addr,
    output commit_pkg::mem_size_e store_size,
    output commit_pkg::word_t     store_data,
    output int                    store_count
);
    import commit_pkg::*;

    logic [31:0] rng;
    logic        reset_s;
    logic        req_s;
    logic        wt_s;
    mem_size_e   size_s;
    word_t       addr_s;
    word_t       wd_s;
    logic        pending;
    word_t       p_addr;
    int          data_cnt;
    int          wait_cnt;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // read data is a function of the word address only.
    function automatic word_t read_word(input word_t a);
        return {a[31:2], 2'b00} ^ 32'h5A5A5A5A;
    endfunction

    initial
    begin
        rng = SEED;
        reset_s = 1'b1;
        req_s = 1'b0;
        wt_s = 1'b0;
        size_s = SIZE_BYTE;
        addr_s = '0;
        wd_s = '0;
        pending = 1'b0;
        p_addr = '0;
        data_cnt = 0;
        wait_cnt = 0;
        dmem_addr_ok = 1'b0;
        dmem_data_ok = 1'b0;
        dmem_rd = '0;
        store_valid = 1'b0;
        store_addr = '0;
        store_size = SIZE_BYTE;
        store_data = '0;
        store_count = 0;
    end

    // the request is settled by mid-cycle.
    always @(negedge clk)
    begin
        reset_s = reset;
        req_s = dmem_req;
        wt_s = dmem_wt;
        size_s = dmem_size;
        addr_s = dmem_addr;
        wd_s = dmem_wd;
    end

    always @(posedge clk)
    begin
        #1;
        store_valid = 1'b0;
        if (reset_s)
        begin
            pending = 1'b0;
            wait_cnt = 0;
            dmem_addr_ok = 1'b0;
            dmem_data_ok = 1'b0;
        end
        else
        begin
            if (dmem_data_ok)
            begin
                dmem_data_ok = 1'b0;
                pending = 1'b0;
            end
            else if (pending)
            begin
                if (data_cnt == 0)
                begin
                    dmem_data_ok = 1'b1;
                    dmem_rd = read_word(p_addr);
                end
                else
                    data_cnt = data_cnt - 1;
            end
            if (dmem_addr_ok && req_s)
            begin
                rng = xorshift(rng);
                pending = 1'b1;
                p_addr = addr_s;
                data_cnt = int'(rng[3:0]) % 3;
                wait_cnt = int'(rng[9:8]);
                if (wt_s)
                begin
                    store_valid = 1'b1;
                    store_addr = addr_s;
                    store_size = size_s;
                    store_data = wd_s;
                    store_count = store_count + 1;
                end
                // data comes one to three cycles after the address.
                if (data_cnt == 0)
                begin
                    dmem_data_ok = 1'b1;
                    dmem_rd = read_word(p_addr);
                end
                else
                    data_cnt = data_cnt - 1;
            end
            else if (!pending && req_s && wait_cnt != 0)
                wait_cnt = wait_cnt - 1;
            dmem_addr_ok = !pending && wait_cnt == 0;
        end
    end

endmodule

`default_nettype wire

//--- rtl/commit_stage.sv
`timescale 1ns/1ns
`default_nettype none

`include "commit_params.svh"

module commit_stage (
    input  logic                                     clk,
    input  logic                                     reset,
    input  commit_pkg::exec_bundle_t                 in,
    input  logic                                     in_valid,
    input  logic                                     irq,
    output logic                                     finish,
    output logic                                     dmem_req,
    output logic                                     dmem_wt,
    output commit_pkg::mem_size_e                    dmem_size,
    output commit_pkg::word_t                        dmem_addr,
    output commit_pkg::word_t                        dmem_wd,
    input  logic                                     dmem_addr_ok,
    input  logic                                     dmem_data_ok,
    input  commit_pkg::word_t                        dmem_rd,
    output commit_pkg::writeback_t [`COMMIT_SLOTS-1:0] wb,
    output commit_pkg::redirect_t                    redirect,
    output commit_pkg::exception_t                   exception
);
    import commit_pkg::*;

    exec_bundle_t ec_bundle;
    exec_bundle_t cd_bundle;
    commit_side_t ec_side;
    commit_side_t cd_side;
    logic         finish_exception;
    logic         finish_cdata;
    logic         flush;

    exception_check u_exception_check (
        .clk,
        .reset,
        .in,
        .in_valid,
        .irq,
        .flush,
        .advance (finish),
        .dmem_addr_ok,
        .out     (ec_bundle),
        .exc     (ec_side.exc),
        .mem     (ec_side.mem),
        .finish_exception,
        .dmem_req,
        .dmem_wt,
        .dmem_size,
        .dmem_addr,
        .dmem_wd
    );

    stage_reg #(.T(exec_bundle_t)) u_bundle_reg (
        .clk,
        .reset,
        .load  (finish),
        .clear (flush),
        .d     (ec_bundle),
        .q     (cd_bundle)
    );

    stage_reg #(.T(commit_side_t)) u_side_reg (
        .clk,
        .reset,
        .load  (finish),
        .clear (flush),
        .d     (ec_side),
        .q     (cd_side)
    );

    data_commit u_data_commit (
        .clk,
        .reset,
        .advance (finish),
        .in      (cd_bundle),
        .side    (cd_side),
        .dmem_data_ok,
        .dmem_rd,
        .finish_cdata,
        .wb,
        .redirect,
        .exception,
        .flush
    );

    // both halves must be done before the bundle moves.
    assign finish = finish_exception & finish_cdata;

endmodule

`default_nettype wire

//--- rtl/data_commit.sv
`timescale 1ns/1ns
`default_nettype none

`include "commit_params.svh"

module data_commit (
    input  logic                                     clk,
    input  logic                                     reset,
    input  logic                                     advance,
    input  commit_pkg::exec_bundle_t                 in,
    input  commit_pkg::commit_side_t                 side,
    input  logic                                     dmem_data_ok,
    input  commit_pkg::word_t                        dmem_rd,
    output logic                                     finish_cdata,
    output commit_pkg::writeback_t [`COMMIT_SLOTS-1:0] wb,
    output commit_pkg::redirect_t                    redirect,
    output commit_pkg::exception_t                   exception,
    output logic                                     flush
);
    import commit_pkg::*;

    logic                     data_got;
    logic                     drain;
    logic                     data_here;
    logic                     taken;
    logic [`COMMIT_SLOTS-1:0] killed;
    logic [`COMMIT_SLOTS-1:0] writes;
    logic [7:0]               byte_v;
    logic [15:0]              half_v;
    word_t                    rd_hold;
    word_t                    rd_word;
    word_t                    load_value;

    assign data_here = data_got || dmem_data_ok;
    assign rd_word = data_got ? rd_hold : dmem_rd;

    // the flush cycle stalls so the next bundle is not loaded into a clearing register.
    assign finish_cdata = !flush && !(side.mem.active && !data_here);

    ////////////////////////////////////////
    // load alignment.
    ////////////////////////////////////////

    always_comb
    begin
        byte_v = rd_word[8*side.mem.offset +: 8];
        half_v = rd_word[16*side.mem.offset[1] +: 16];
        case (side.mem.size)
            SIZE_BYTE: load_value = {{(`COMMIT_DATA_W-8){side.mem.sign_ext & byte_v[7]}}, byte_v};
            SIZE_HALF: load_value = {{(`COMMIT_DATA_W-16){side.mem.sign_ext & half_v[15]}}, half_v};
            default:   load_value = rd_word;
        endcase
    end

    ////////////////////////////////////////
    // commit outputs.
    ////////////////////////////////////////

    always_comb
    begin
        for (int i = 0; i < `COMMIT_SLOTS; i++)
        begin
            killed[i] = side.exc.valid && i >= int'(side.exc.slot);
            case (in[i].kind)
                OP_LOAD:           writes[i] = 1'b1;
                OP_ALU, OP_BRANCH: writes[i] = in[i].dest != 5'd0;
                default:           writes[i] = 1'b0;
            endcase
            wb[i].valid = advance && in[i].valid && !killed[i] && writes[i];
            wb[i].dest = in[i].dest;
            wb[i].value = (in[i].kind == OP_LOAD) ? load_value : in[i].result;
        end
    end

    always_comb
    begin
        redirect = '0;
        taken = 1'b0;
        redirect.from_exception = side.exc.valid;
        if (side.exc.valid)
        begin
            taken = 1'b1;
            redirect.pc = `COMMIT_EXC_VECTOR;
        end
        else
        begin
            // walk down so the oldest taken branch wins.
            for (int i = `COMMIT_SLOTS - 1; i >= 0; i--)
            begin
                if (in[i].valid && in[i].kind == OP_BRANCH && in[i].branch_taken)
                begin
                    taken = 1'b1;
                    redirect.pc = in[i].branch_target;
                end
            end
        end
        redirect.valid = advance && taken;
    end

    always_comb
    begin
        exception = side.exc;
        exception.valid = advance && side.exc.valid;
    end

    ////////////////////////////////////////
    // data phase state.
    ////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            data_got <= 1'b0;
            drain <= 1'b0;
            flush <= 1'b0;
        end
        else
        begin
            flush <= exception.valid;
            if (advance || flush)
                data_got <= 1'b0;
            else if (dmem_data_ok && side.mem.active && !drain)
                data_got <= 1'b1;
            // a flushed access still owes one data_ok.
            if (dmem_data_ok)
                drain <= 1'b0;
            else if (flush && side.mem.active && !data_got)
                drain <= 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (dmem_data_ok)
            rd_hold <= dmem_rd;
    end

    a_data_ok_owned: assert property (@(posedge clk) disable iff (reset)
        dmem_data_ok |-> (side.mem.active && !data_got) || drain)
        else $error("dmem_data_ok with no memory op outstanding");

endmodule

`default_nettype wire

//--- rtl/stage_reg.sv
`timescale 1ns/1ns
`default_nettype none

`include "commit_params.svh"

module stage_reg #(
    parameter type T = logic
) (
    input  logic clk,
    input  logic reset,
    input  logic load,
    input  logic clear,
    input  T     d,
    output T     q
);

    // clear beats load.
    always_ff @(posedge clk)
    begin
        if (reset || clear)
            q <= `COMMIT_REG_RESET;
        else if (load)
            q <= d;
    end

    ////////////////////////////////////////
    // checks.
    ////////////////////////////////////////

    // a flush must not swallow a live payload arriving from the first step.
    a_no_lost_load: assert property (@(posedge clk) disable iff (reset)
        !(load && clear && d != `COMMIT_REG_RESET))
        else $error("stage register load dropped by clear");

endmodule

`default_nettype wire

//--- rtl/exception_check.sv
`timescale 1ns/1ns
`default_nettype none

module exception_check (
    input  logic                     clk,
    input  logic                     reset,
    input  commit_pkg::exec_bundle_t in,
    input  logic                     in_valid,
    input  logic                     irq,
    input  logic                     flush,
    input  logic                     advance,
    input  logic                     dmem_addr_ok,
    output commit_pkg::exec_bundle_t out,
    output commit_pkg::exception_t   exc,
    output commit_pkg::mem_info_t    mem,
    output logic                     finish_exception,
    output logic                     dmem_req,
    output logic                     dmem_wt,
    output commit_pkg::mem_size_e    dmem_size,
    output commit_pkg::word_t        dmem_addr,
    output commit_pkg::word_t        dmem_wd
);
    import commit_pkg::*;

    exc_code_e code0;
    exc_code_e code1;
    logic      take_irq;
    logic      mem_op;
    logic      addr_done;

    function automatic logic is_mem(input exec_data_t s);
        return s.kind == OP_LOAD || s.kind == OP_STORE;
    endfunction

    // per-slot cause, highest priority first.
    function automatic exc_code_e classify(input exec_data_t s);
        logic misaligned;
        misaligned = (s.size == SIZE_HALF && s.result[0])
                  || (s.size == SIZE_WORD && s.result[1:0] != 2'b00);
        if (!s.valid)
            return EXC_NONE;
        if (s.overflow)
            return EXC_OV;
        if (s.kind == OP_SYSCALL)
            return EXC_SYS;
        if (s.kind == OP_BREAK)
            return EXC_BP;
        if (s.kind == OP_LOAD && misaligned)
            return EXC_ADEL;
        if (s.kind == OP_STORE && misaligned)
            return EXC_ADES;
        return EXC_NONE;
    endfunction

    always_comb
    begin
        take_irq = irq && in_valid && in[0].valid;
        code0 = take_irq ? EXC_INT : (in_valid ? classify(in[0]) : EXC_NONE);
        code1 = (in_valid && code0 == EXC_NONE) ? classify(in[1]) : EXC_NONE;

        // a fault in slot 0 kills slot 1.
        out = in;
        out[0].valid = in_valid && in[0].valid;
        out[1].valid = in_valid && in[1].valid && code0 == EXC_NONE;

        exc = '0;
        if (code0 != EXC_NONE)
        begin
            exc.valid = 1'b1;
            exc.code = code0;
            exc.epc = in[0].pc;
            exc.slot = 1'b0;
            if (code0 == EXC_ADEL || code0 == EXC_ADES)
                exc.bad_addr = in[0].result;
        end
        else if (code1 != EXC_NONE)
        begin
            exc.valid = 1'b1;
            exc.code = code1;
            exc.epc = in[1].pc;
            exc.slot = 1'b1;
        end
    end

    ////////////////////////////////////////
    // address phase.
    ////////////////////////////////////////

    assign mem_op = in_valid && in[0].valid && is_mem(in[0]) && code0 == EXC_NONE;

    assign mem.active = mem_op;
    assign mem.is_load = in[0].kind == OP_LOAD;
    assign mem.size = in[0].size;
    assign mem.sign_ext = in[0].sign_ext;
    assign mem.offset = in[0].result[1:0];

    // no new request while the stage register is being flushed.
    assign dmem_req = mem_op && !addr_done && !flush;
    assign dmem_wt = in[0].kind == OP_STORE;
    assign dmem_size = in[0].size;
    assign dmem_addr = in[0].result;

    always_comb
    begin
        case (in[0].size)
            SIZE_BYTE: dmem_wd = {4{in[0].store_data[7:0]}};
            SIZE_HALF: dmem_wd = {2{in[0].store_data[15:0]}};
            default:   dmem_wd = in[0].store_data;
        endcase
    end

    assign finish_exception = !mem_op || addr_done || (dmem_req && dmem_addr_ok);

    // address taken but the bundle is still held by the data phase.
    always_ff @(posedge clk)
    begin
        if (reset || advance)
            addr_done <= 1'b0;
        else if (dmem_req && dmem_addr_ok)
            addr_done <= 1'b1;
    end

    a_req_held: assert property (@(posedge clk) disable iff (reset)
        dmem_req && !dmem_addr_ok |=> dmem_req && $stable(dmem_addr) && $stable(dmem_wt))
        else $error("dmem_req dropped or changed before dmem_addr_ok");

    a_slot1_no_mem: assert property (@(posedge clk) disable iff (reset)
        in_valid && in[1].valid |-> !is_mem(in[1]))
        else $error("memory op issued in slot 1");

endmodule

`default_nettype wire

//--- rtl/commit_pkg.sv
`default_nettype none

`include "commit_params.svh"

package commit_pkg;

    typedef logic [`COMMIT_DATA_W-1:0] word_t;

    ////////////////////////////////////////
    // encodings.
    ////////////////////////////////////////

    typedef enum logic [2:0] {
        OP_NONE,
        OP_ALU,
        OP_LOAD,
        OP_STORE,
        OP_BRANCH,
        OP_SYSCALL,
        OP_BREAK
    } op_kind_e;

    typedef enum logic [1:0] {
        SIZE_BYTE,
        SIZE_HALF,
        SIZE_WORD
    } mem_size_e;

    typedef enum logic [2:0] {
        EXC_NONE,
        EXC_INT,
        EXC_ADEL,
        EXC_ADES,
        EXC_OV,
        EXC_SYS,
        EXC_BP
    } exc_code_e;

    ////////////////////////////////////////
    // payloads.
    ////////////////////////////////////////

    // one executed instruction; result is the address for a memory op.
    typedef struct packed {
        logic      valid;
        word_t     pc;
        op_kind_e  kind;
        mem_size_e size;
        logic      sign_ext;
        logic      overflow;
        logic [4:0] dest;
        word_t     result;
        word_t     store_data;
        logic      branch_taken;
        word_t     branch_target;
    } exec_data_t;

    typedef exec_data_t [`COMMIT_SLOTS-1:0] exec_bundle_t;

    typedef struct packed {
        logic      valid;
        exc_code_e code;
        word_t     epc;
        word_t     bad_addr;
        logic      slot;
    } exception_t;

    // memory state handed from the address phase to the data phase.
    typedef struct packed {
        logic      active;
        logic      is_load;
        mem_size_e size;
        logic      sign_ext;
        logic [1:0] offset;
    } mem_info_t;

    typedef struct packed {
        exception_t exc;
        mem_info_t  mem;
    } commit_side_t;

    typedef struct packed {
        logic       valid;
        logic [4:0] dest;
        word_t      value;
    } writeback_t;

    typedef struct packed {
        logic  valid;
        word_t pc;
        logic  from_exception;
    } redirect_t;

endpackage

`default_nettype wire

//--- rtl/commit_params.svh
`ifndef COMMIT_PARAMS_SVH
`define COMMIT_PARAMS_SVH

////////////////////////////////////////
// commit stage sizing.
////////////////////////////////////////

// width of a data word and of every address.
`define COMMIT_DATA_W 32

// target of the fetch redirect on any exception.
`define COMMIT_EXC_VECTOR 32'hBFC00380

// issue width of a bundle.
`define COMMIT_SLOTS 2

// value a stage register takes on reset or flush.
`define COMMIT_REG_RESET '0

`endif
